/* src/retire_pkg.sv */
// sized for two commit ports and 16-entry PC queues; PcQueueDepth must stay a power of two
package retire_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int unsigned NrCommitPorts = 2;
  localparam int unsigned PcQueueDepth  = 16;
  localparam int unsigned Vlen          = 32;
  localparam int unsigned Xlen          = 32;
  // queue pointer width, wraps naturally at the depth
  localparam int unsigned PtrWidth      = $clog2(PcQueueDepth);

  // ----------------------------------------
  // vector types
  // ----------------------------------------
  typedef logic [Vlen-1:0] vaddr_t;
  typedef logic [31:0]     insn_t;
  // top bit set means interrupt
  typedef logic [Xlen-1:0] cause_t;
  typedef logic [31:0]     cycle_t;
  typedef logic            port_idx_t;
  // holds 0 .. PcQueueDepth
  typedef logic [4:0]      queue_cnt_t;

  // privilege level, encoding 2 is reserved
  typedef enum logic [1:0] {
    PrivLvlU = 2'd0,
    PrivLvlS = 2'd1,
    PrivLvlM = 2'd3
  } priv_lvl_e;

  // ----------------------------------------
  // commit side records
  // ----------------------------------------

  // what one commit port offers
  typedef struct packed {
    vaddr_t pc;
    insn_t  insn;
    logic   ex_valid;
    cause_t cause;
  } commit_entry_t;

  // one registered trace record
  typedef struct packed {
    logic      valid;
    logic      exception;
    logic      interrupt;
    vaddr_t    iaddr;
    insn_t     insn;
    priv_lvl_e priv;
    cause_t    cause;
    cycle_t    stamp;
  } trace_port_t;

endpackage

/* src/commit_classifier.sv */
// trace records lag the commit by exactly one cycle; the stamp counter wraps at 32 bits
module commit_classifier (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  retire_pkg::commit_entry_t [retire_pkg::NrCommitPorts-1:0] commit_i,
  input  logic [retire_pkg::NrCommitPorts-1:0]                   commit_ack_i,
  input  retire_pkg::priv_lvl_e                                  priv_lvl_i,
  output retire_pkg::trace_port_t   [retire_pkg::NrCommitPorts-1:0] trace_o
);

  import retire_pkg::*;

  // edges seen since reset release, before the current one
  cycle_t stamp_q;

  trace_port_t [NrCommitPorts-1:0] trace_d;
  trace_port_t [NrCommitPorts-1:0] trace_q;

  // ----------------------------------------
  // cycle stamp
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stamp_q <= '0;
    end else begin
      stamp_q <= stamp_q + cycle_t'(1);
    end
  end

  // ----------------------------------------
  // classification
  // ----------------------------------------
  always_comb begin
    for (int unsigned i = 0; i < NrCommitPorts; i++) begin
      // flags are mutually exclusive
      trace_d[i].valid     = commit_ack_i[i] & ~commit_i[i].ex_valid;
      trace_d[i].exception = commit_ack_i[i] & commit_i[i].ex_valid &
                             ~commit_i[i].cause[Xlen-1];
      trace_d[i].interrupt = commit_ack_i[i] & commit_i[i].ex_valid &
                             commit_i[i].cause[Xlen-1];
      // payload follows the port regardless of the flags
      trace_d[i].iaddr     = commit_i[i].pc;
      trace_d[i].insn      = commit_i[i].insn;
      trace_d[i].priv      = priv_lvl_i;
      trace_d[i].cause     = commit_i[i].cause;
      trace_d[i].stamp     = stamp_q;
    end
  end

  // ----------------------------------------
  // record registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trace_q <= '0;
    end else begin
      trace_q <= trace_d;
    end
  end

  assign trace_o = trace_q;

endmodule

/* src/pc_queue.sv */
// head is read combinationally; a push into a full queue without a pop is dropped
module pc_queue (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               push_i,
  input  retire_pkg::vaddr_t pc_i,
  input  logic               pop_i,
  output logic               empty_o,
  output retire_pkg::vaddr_t head_o,
  output logic               lost_o
);

  import retire_pkg::*;

  // storage, written only on an accepted push
  vaddr_t mem_q [PcQueueDepth];

  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth-1:0] wr_ptr_q;
  queue_cnt_t          cnt_q;
  logic                lost_q;

  logic full;
  logic push_ok;
  logic pop_ok;

  assign full    = (cnt_q == queue_cnt_t'(PcQueueDepth));
  assign empty_o = (cnt_q == '0);

  // a pop in the same cycle frees the slot for the push
  assign push_ok = push_i & (~full | pop_i);
  assign pop_ok  = pop_i & ~empty_o;

  // ----------------------------------------
  // pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   cnt_q <= cnt_q + queue_cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - queue_cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= pc_i;
    end
  end

  assign head_o = mem_q[rd_ptr_q];

  // ----------------------------------------
  // loss flag
  // ----------------------------------------

  // sticky until the next reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lost_q <= 1'b0;
    end else if (push_i && !push_ok) begin
      lost_q <= 1'b1;
    end
  end

  assign lost_o = lost_q;

endmodule

/* src/pc_arbiter.sv */
// grants every cycle a queue is non-empty; the consumer never stalls
module pc_arbiter (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic [retire_pkg::NrCommitPorts-1:0]              empty_i,
  input  retire_pkg::vaddr_t [retire_pkg::NrCommitPorts-1:0] head_i,
  output logic [retire_pkg::NrCommitPorts-1:0]              pop_o,
  output logic                                              pc_valid_o,
  output retire_pkg::vaddr_t                                pc_o,
  output retire_pkg::port_idx_t                             pc_port_o
);

  import retire_pkg::*;

  // port granted most recently
  port_idx_t last_q;
  port_idx_t gnt_idx;
  port_idx_t cand;
  logic      found;

  assign pc_valid_o = ~&empty_i;

  // ----------------------------------------
  // round-robin search
  // ----------------------------------------

  // start one past the last grant and take the first non-empty port
  always_comb begin
    gnt_idx = last_q;
    found   = 1'b0;
    cand    = last_q;
    for (int unsigned k = 1; k <= NrCommitPorts; k++) begin
      cand = port_idx_t'((int'(last_q) + k) % NrCommitPorts);
      if (!found && !empty_i[cand]) begin
        gnt_idx = cand;
        found   = 1'b1;
      end
    end
  end

  always_comb begin
    pop_o          = '0;
    pop_o[gnt_idx] = pc_valid_o;
  end

  assign pc_o      = head_i[gnt_idx];
  assign pc_port_o = gnt_idx;

  // ----------------------------------------
  // grant history
  // ----------------------------------------

  // reset to the last port so port 0 wins first
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= port_idx_t'(NrCommitPorts - 1);
    end else if (pc_valid_o) begin
      last_q <= gnt_idx;
    end
  end

endmodule

/* src/retire_monitor.sv */
// observes commit ports only; the PC stream has no back-pressure and must be consumed each cycle
module retire_monitor (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  retire_pkg::commit_entry_t [retire_pkg::NrCommitPorts-1:0] commit_i,
  input  logic [retire_pkg::NrCommitPorts-1:0]                   commit_ack_i,
  input  retire_pkg::priv_lvl_e                                  priv_lvl_i,
  output retire_pkg::trace_port_t   [retire_pkg::NrCommitPorts-1:0] trace_o,
  output logic                                                   pc_valid_o,
  output retire_pkg::vaddr_t                                     pc_o,
  output retire_pkg::port_idx_t                                  pc_port_o,
  output logic                                                   pc_lost_o
);

  import retire_pkg::*;

  logic   [NrCommitPorts-1:0] pc_push;
  logic   [NrCommitPorts-1:0] pc_pop;
  logic   [NrCommitPorts-1:0] pc_empty;
  logic   [NrCommitPorts-1:0] pc_lost;
  vaddr_t [NrCommitPorts-1:0] pc_head;

  // ----------------------------------------
  // trace records
  // ----------------------------------------
  commit_classifier u_commit_classifier (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .commit_i     ( commit_i     ),
    .commit_ack_i ( commit_ack_i ),
    .priv_lvl_i   ( priv_lvl_i   ),
    .trace_o      ( trace_o      )
  );

  // ----------------------------------------
  // per-port PC queues
  // ----------------------------------------
  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_pc_queue
    // only clean retirements, traps stay off the stream
    assign pc_push[i] = commit_ack_i[i] & ~commit_i[i].ex_valid;

    pc_queue u_pc_queue (
      .clk_i   ( clk_i          ),
      .rst_ni  ( rst_ni         ),
      .push_i  ( pc_push[i]     ),
      .pc_i    ( commit_i[i].pc ),
      .pop_i   ( pc_pop[i]      ),
      .empty_o ( pc_empty[i]    ),
      .head_o  ( pc_head[i]     ),
      .lost_o  ( pc_lost[i]     )
    );
  end

  // any queue overflowing counts
  assign pc_lost_o = |pc_lost;

  // ----------------------------------------
  // drain onto one stream
  // ----------------------------------------
  pc_arbiter u_pc_arbiter (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .empty_i    ( pc_empty   ),
    .head_i     ( pc_head    ),
    .pop_o      ( pc_pop     ),
    .pc_valid_o ( pc_valid_o ),
    .pc_o       ( pc_o       ),
    .pc_port_o  ( pc_port_o  )
  );

endmodule

/* verif/retire_monitor_assert.sv */
// bound into retire_monitor; checks are off while rst_ni is low and fail_count is read by the testbench
module retire_monitor_assert (
  input logic                                                   clk_i,
  input logic                                                   rst_ni,
  input retire_pkg::commit_entry_t [retire_pkg::NrCommitPorts-1:0] commit_i,
  input logic [retire_pkg::NrCommitPorts-1:0]                   commit_ack_i,
  input retire_pkg::trace_port_t   [retire_pkg::NrCommitPorts-1:0] trace_o,
  input logic                                                   pc_valid_o,
  input retire_pkg::port_idx_t                                  pc_port_o,
  input logic                                                   pc_lost_o,
  input logic [retire_pkg::NrCommitPorts-1:0]                   pc_empty_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import retire_pkg::*;

  int unsigned fail_count = 0;

  // ----------------------------------------
  // per-port trace records
  // ----------------------------------------
  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_port
    flags_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0({trace_o[i].valid, trace_o[i].exception, trace_o[i].interrupt}))
      else begin
        $error("more than one trace flag set on port %0d", i);
        fail_count++;
      end

    retire_marks_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      commit_ack_i[i] && !commit_i[i].ex_valid |=> trace_o[i].valid)
      else begin
        $error("retirement on port %0d not marked valid", i);
        fail_count++;
      end

    trap_marks_flag: assert property (@(posedge clk_i) disable iff (!rst_ni)
      commit_ack_i[i] && commit_i[i].ex_valid |=>
        (trace_o[i].exception || trace_o[i].interrupt))
      else begin
        $error("trap on port %0d left no trace flag", i);
        fail_count++;
      end

    // no ack, no flags one cycle later
    idle_port_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !commit_ack_i[i] |=>
        !(trace_o[i].valid || trace_o[i].exception || trace_o[i].interrupt))
      else begin
        $error("idle port %0d shows a trace flag", i);
        fail_count++;
      end
  end

  // ----------------------------------------
  // stream and loss flag
  // ----------------------------------------

  // the granted port has to hold a PC
  grant_non_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_valid_o |-> !pc_empty_i[pc_port_o])
    else begin
      $error("pc_port_o names an empty queue");
      fail_count++;
    end

  // both heads waiting, so the grant has to move on
  grant_rotates: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_valid_o && (pc_empty_i == '0) && $past(pc_valid_o) |-> pc_port_o != $past(pc_port_o))
    else begin
      $error("same port granted twice while both queues were non-empty");
      fail_count++;
    end

  lost_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_lost_o |=> pc_lost_o)
    else begin
      $error("pc_lost_o dropped without reset");
      fail_count++;
    end

  stamp_step: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) && $past(rst_ni, 2) |->
      trace_o[0].stamp == $past(trace_o[0].stamp) + cycle_t'(1))
    else begin
      $error("cycle stamp did not advance by one");
      fail_count++;
    end

endmodule

bind retire_monitor retire_monitor_assert u_retire_monitor_assert (
  .clk_i        ( clk_i        ),
  .rst_ni       ( rst_ni       ),
  .commit_i     ( commit_i     ),
  .commit_ack_i ( commit_ack_i ),
  .trace_o      ( trace_o      ),
  .pc_valid_o   ( pc_valid_o   ),
  .pc_port_o    ( pc_port_o    ),
  .pc_lost_o    ( pc_lost_o    ),
  .pc_empty_i   ( pc_empty     )
);

/* verif/tb_retire_monitor.sv */
// random commits from a fixed seed; outputs are sampled on the falling edge, the run stops at the first mismatch
module tb_retire_monitor;

  timeunit 1ns;
  timeprecision 100ps;

  import retire_pkg::*;

  localparam int unsigned ClkPeriod   = 8;
  localparam int unsigned ResetCycles = 5;
  localparam int unsigned MixCycles   = 120;
  localparam int unsigned DrainCycles = 40;
  localparam int unsigned BurstCycles = 40;
  localparam int unsigned TailCycles  = 10;
  localparam int unsigned TotalCycles = 2 * ResetCycles + MixCycles + 2 * DrainCycles +
                                        BurstCycles + TailCycles + 4;

  int seed = 96839;

  logic                                  clk_i;
  logic                                  rst_ni;
  commit_entry_t [NrCommitPorts-1:0]     commit_i;
  logic          [NrCommitPorts-1:0]     commit_ack_i;
  priv_lvl_e                             priv_lvl_i;
  trace_port_t   [NrCommitPorts-1:0]     trace_o;
  logic                                  pc_valid_o;
  vaddr_t                                pc_o;
  port_idx_t                             pc_port_o;
  logic                                  pc_lost_o;

  // reference model state
  vaddr_t      ref_q [NrCommitPorts][$];
  trace_port_t exp_trace [NrCommitPorts];
  cycle_t      exp_stamp;
  logic        exp_lost;
  port_idx_t   exp_last;

  retire_monitor u_retire_monitor (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .commit_i     ( commit_i     ),
    .commit_ack_i ( commit_ack_i ),
    .priv_lvl_i   ( priv_lvl_i   ),
    .trace_o      ( trace_o      ),
    .pc_valid_o   ( pc_valid_o   ),
    .pc_o         ( pc_o         ),
    .pc_port_o    ( pc_port_o    ),
    .pc_lost_o    ( pc_lost_o    )
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic stop_on_error();
    $display("ERRORS FOUND");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_eq(input string test_name, input logic [31:0] expected,
                          input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAILED %s expected %h actual %h", test_name, expected, actual);
      stop_on_error();
    end
  endtask

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic port_idx_t next_grant();
    port_idx_t p;
    for (int unsigned k = 1; k <= NrCommitPorts; k++) begin
      p = port_idx_t'((exp_last + k) % NrCommitPorts);
      if (ref_q[p].size() != 0) begin
        return p;
      end
    end
    return exp_last;
  endfunction

  task automatic compare_trace();
    for (int unsigned i = 0; i < NrCommitPorts; i++) begin
      check_eq($sformatf("classify_flags_p%0d", i),
               {exp_trace[i].valid, exp_trace[i].exception, exp_trace[i].interrupt},
               {trace_o[i].valid, trace_o[i].exception, trace_o[i].interrupt});
      check_eq($sformatf("classify_iaddr_p%0d", i), exp_trace[i].iaddr, trace_o[i].iaddr);
      check_eq($sformatf("classify_insn_p%0d", i), exp_trace[i].insn, trace_o[i].insn);
      check_eq($sformatf("classify_priv_p%0d", i), exp_trace[i].priv, trace_o[i].priv);
      check_eq($sformatf("classify_cause_p%0d", i), exp_trace[i].cause, trace_o[i].cause);
      check_eq($sformatf("stamp_p%0d", i), exp_trace[i].stamp, trace_o[i].stamp);
    end
  endtask

  // one PC per cycle from the next non-empty port after the last grant
  task automatic compare_stream();
    logic      any_entry;
    port_idx_t gp;
    any_entry = 1'b0;
    for (int unsigned i = 0; i < NrCommitPorts; i++) begin
      any_entry = any_entry | (ref_q[i].size() != 0);
    end
    check_eq("stream_valid", any_entry, pc_valid_o);
    if (any_entry) begin
      gp = next_grant();
      check_eq("stream_port", gp, pc_port_o);
      check_eq("stream_pc", ref_q[gp][0], pc_o);
      void'(ref_q[gp].pop_front());
      exp_last = gp;
    end
  endtask

  task automatic update_model();
    logic ack;
    logic ex;
    for (int unsigned i = 0; i < NrCommitPorts; i++) begin
      ack = commit_ack_i[i];
      ex  = commit_i[i].ex_valid;
      if (ack && !ex) begin
        if (ref_q[i].size() >= PcQueueDepth) begin
          exp_lost = 1'b1;
        end else begin
          ref_q[i].push_back(commit_i[i].pc);
        end
      end
      exp_trace[i].valid     = ack && !ex;
      exp_trace[i].exception = ack && ex && !commit_i[i].cause[Xlen-1];
      exp_trace[i].interrupt = ack && ex && commit_i[i].cause[Xlen-1];
      exp_trace[i].iaddr     = commit_i[i].pc;
      exp_trace[i].insn      = commit_i[i].insn;
      exp_trace[i].priv      = priv_lvl_i;
      exp_trace[i].cause     = commit_i[i].cause;
      exp_trace[i].stamp     = exp_stamp;
    end
    exp_stamp = exp_stamp + cycle_t'(1);
  endtask

  always @(negedge clk_i) begin
    if (u_retire_monitor.u_retire_monitor_assert.fail_count != 0) begin
      $display("a concurrent check bound to the DUT has failed");
      stop_on_error();
    end
    if (!rst_ni) begin
      for (int unsigned i = 0; i < NrCommitPorts; i++) begin
        check_eq($sformatf("reset_flags_p%0d", i), 32'd0,
                 {trace_o[i].valid, trace_o[i].exception, trace_o[i].interrupt});
        ref_q[i].delete();
        exp_trace[i] = '0;
      end
      check_eq("reset_pc_valid", 32'd0, pc_valid_o);
      check_eq("reset_pc_lost", 32'd0, pc_lost_o);
      exp_stamp = '0;
      exp_lost  = 1'b0;
      exp_last  = port_idx_t'(NrCommitPorts - 1);
    end else begin
      compare_trace();
      compare_stream();
      check_eq("pc_lost", exp_lost, pc_lost_o);
      update_model();
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  function automatic commit_entry_t random_entry(input logic ex);
    commit_entry_t e;
    e.pc       = vaddr_t'($random(seed)) & ~vaddr_t'(3);
    e.insn     = insn_t'($random(seed));
    e.ex_valid = ex;
    e.cause    = cause_t'($random(seed));
    return e;
  endfunction

  task automatic apply_reset();
    rst_ni       = 1'b0;
    commit_ack_i = '0;
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
  endtask

  // mode 0 idle, 1 random mix, 2 clean retirement on every port
  task automatic drive_cycles(input int unsigned cycles, input int unsigned mode);
    repeat (cycles) begin
      @(posedge clk_i);
      #1;
      for (int unsigned i = 0; i < NrCommitPorts; i++) begin
        commit_i[i]     = random_entry((mode != 2) && (($random(seed) & 3) == 0));
        commit_ack_i[i] = (mode == 2) || ((mode == 1) && (($random(seed) & 1) != 0));
      end
      case ($random(seed) & 3)
        0:       priv_lvl_i = PrivLvlU;
        1:       priv_lvl_i = PrivLvlS;
        default: priv_lvl_i = PrivLvlM;
      endcase
    end
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    commit_i     = '0;
    commit_ack_i = '0;
    priv_lvl_i   = PrivLvlM;
    apply_reset();
    drive_cycles(MixCycles, 1);
    drive_cycles(DrainCycles, 0);
    @(negedge clk_i);
    #1;
    // every queue in the DUT has drained
    check_eq("drain_pc_valid", 32'd0, pc_valid_o);
    // two pushes per cycle against one pop fills the queues
    drive_cycles(BurstCycles, 2);
    @(negedge clk_i);
    #1;
    check_eq("burst_lost", 32'd1, pc_lost_o);
    drive_cycles(DrainCycles, 0);
    apply_reset();
    drive_cycles(TailCycles, 0);
    @(negedge clk_i);
    #1;
    if (u_retire_monitor.u_retire_monitor_assert.fail_count != 0) begin
      $display("a concurrent check bound to the DUT has failed");
      stop_on_error();
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

  // watchdog
  initial begin
    #((TotalCycles + 200) * ClkPeriod);
    $display("watchdog expired before the test sequence finished");
    stop_on_error();
  end

endmodule

/* sources.f */
src/retire_pkg.sv
src/commit_classifier.sv
src/pc_queue.sv
src/pc_arbiter.sv
src/retire_monitor.sv
verif/retire_monitor_assert.sv
verif/tb_retire_monitor.sv

/* run_sim.sh */
#!/bin/sh
# build and run the retire monitor testbench, verdict taken from sim.log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_retire_monitor \
  -f sources.f -o tb_retire_monitor \
  || { echo "build failed"; exit 1; }
./obj_dir/tb_retire_monitor +verilator+error+limit+100 > sim.log 2>&1 \
  || echo "simulation returned a failing status"
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "RESULT: FAIL"; exit 1; }
echo "RESULT: PASS"
